// File: Makefile
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --assert --top-module stq_tb -f tb.f

sim:
	verilator --binary --timing --assert --top-module stq_tb -f tb.f -o stq_sim
	./obj_dir/stq_sim | tee $(LOG)
	@grep -q "RESULT: PASS" $(LOG) || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// File: design/stq_drain.sv
`timescale 1ns/1ps
`default_nettype none

module stq_drain (
  input  logic                i_clk,
  input  logic                i_reset_n,
  input  stq_pkg::stq_entry_t i_head_entry,
  input  logic                i_head_committed,
  input  logic                i_stb_ready,
  output logic                o_pop,
  output logic                o_stb_valid,
  output stq_pkg::stb_req_t   o_stb
);
  import stq_pkg::*;

  logic     r_valid;
  stb_req_t r_stb;
  stb_req_t w_stb_next;
  logic     w_free;
  logic     w_load;

  // Register can take a new request when empty or handing off this cycle
  assign w_free = ~r_valid | i_stb_ready;
  assign w_load = i_head_committed & w_free;
  assign o_pop  = w_load;

  assign w_stb_next.addr = {i_head_entry.dw_addr, {DW_OFS_W{1'b0}}};
  assign w_stb_next.strb = i_head_entry.byte_en;
  assign w_stb_next.data = i_head_entry.data;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= 1'b0;
    end else if (w_load) begin
      r_valid <= 1'b1;
    end else if (i_stb_ready) begin
      r_valid <= 1'b0;   // Transfer with nothing behind it
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_load) begin
      r_stb <= w_stb_next;
    end
  end

  assign o_stb_valid = r_valid;
  assign o_stb       = r_stb;

endmodule

`default_nettype wire

// File: design/stq_entry_array.sv
`timescale 1ns/1ps
`default_nettype none

module stq_entry_array (
  input  logic                                       i_clk,
  input  logic                                       i_reset_n,
  input  logic                                       i_wr_en,
  input  stq_pkg::stq_idx_t                          i_wr_idx,
  input  stq_pkg::st_req_t                           i_st,
  output stq_pkg::stq_entry_t [stq_pkg::STQ_SIZE-1:0] o_entries
);
  import stq_pkg::*;

  logic [DW_OFS_W-1:0]        w_ofs;
  stq_entry_t                 w_wr_entry;
  logic [DW_BYTES-1:0]        r_byte_en [STQ_SIZE];
  logic [ADDR_W-DW_OFS_W-1:0] r_dw_addr [STQ_SIZE];
  logic [DATA_W-1:0]          r_data    [STQ_SIZE];

  assign w_ofs = i_st.addr[DW_OFS_W-1:0];

  // Move the store into its double-word lanes
  assign w_wr_entry.dw_addr = i_st.addr[ADDR_W-1:DW_OFS_W];
  assign w_wr_entry.byte_en = size_mask(i_st.size) << w_ofs;
  assign w_wr_entry.data    = i_st.data << {w_ofs, 3'b000};

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 0; i < STQ_SIZE; i++) begin
        r_byte_en[i] <= '0;
      end
    end else if (i_wr_en) begin
      r_byte_en[i_wr_idx] <= w_wr_entry.byte_en;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_wr_en) begin
      r_dw_addr[i_wr_idx] <= w_wr_entry.dw_addr;
      r_data[i_wr_idx]    <= w_wr_entry.data;
    end
  end

  always_comb begin
    for (int i = 0; i < STQ_SIZE; i++) begin
      o_entries[i].dw_addr = r_dw_addr[i];
      o_entries[i].byte_en = r_byte_en[i];
      o_entries[i].data    = r_data[i];
    end
  end

endmodule

`default_nettype wire

// File: design/stq_fwd_unit.sv
`timescale 1ns/1ps
`default_nettype none

module stq_fwd_unit (
  input  stq_pkg::stq_entry_t [stq_pkg::STQ_SIZE-1:0] i_entries,
  input  logic [stq_pkg::STQ_SIZE-1:0]                i_valid_mask,
  input  stq_pkg::stq_idx_t                           i_tail_idx,
  input  stq_pkg::fwd_query_t                         i_fwd,
  output stq_pkg::fwd_resp_t                          o_fwd
);
  import stq_pkg::*;

  logic [DW_BYTES-1:0]        w_q_be;
  logic [ADDR_W-DW_OFS_W-1:0] w_q_dw;
  logic [STQ_SIZE-1:0]        w_dw_match;
  logic [DW_BYTES-1:0]        w_hit_be;
  logic [DATA_W-1:0]          w_data;

  assign w_q_be = size_mask(i_fwd.size) << i_fwd.addr[DW_OFS_W-1:0];
  assign w_q_dw = i_fwd.addr[ADDR_W-1:DW_OFS_W];

  always_comb begin
    for (int e = 0; e < STQ_SIZE; e++) begin
      w_dw_match[e] = i_fwd.valid & i_valid_mask[e] & (i_entries[e].dw_addr == w_q_dw);
    end
  end

  // ==========================================================================
  // Per-byte youngest match
  // ==========================================================================
  for (genvar b = 0; b < DW_BYTES; b++) begin : g_byte
    logic [STQ_SIZE-1:0]   w_hit_vec;
    logic [2*STQ_SIZE-1:0] w_hit_dbl;
    logic [STQ_SIZE-1:0]   w_hit_rot;
    stq_idx_t              w_win_ofs;
    stq_idx_t              w_win_idx;

    always_comb begin
      for (int e = 0; e < STQ_SIZE; e++) begin
        w_hit_vec[e] = w_dw_match[e] & i_entries[e].byte_en[b] & w_q_be[b];
      end
    end

    // After rotation bit 0 is the tail slot and the top bit is tail-1
    assign w_hit_dbl = {w_hit_vec, w_hit_vec} >> i_tail_idx;
    assign w_hit_rot = w_hit_dbl[STQ_SIZE-1:0];

    always_comb begin
      w_win_ofs = '0;
      for (int k = 0; k < STQ_SIZE; k++) begin
        if (w_hit_rot[k]) begin
          w_win_ofs = stq_idx_t'(k);   // Highest set bit is youngest
        end
      end
    end

    assign w_win_idx   = i_tail_idx + w_win_ofs;
    assign w_hit_be[b] = |w_hit_rot;
    assign w_data[b*8 +: 8] = w_hit_be[b] ? i_entries[w_win_idx].data[b*8 +: 8] : 8'h00;
  end

  assign o_fwd.hit_be = w_hit_be;
  assign o_fwd.data   = w_data;

endmodule

`default_nettype wire

// File: design/stq_pkg.sv
`default_nettype none

package stq_pkg;

  // ==========================================================================
  // Queue geometry
  // ==========================================================================
  localparam int STQ_SIZE  = 8;
  localparam int STQ_IDX_W = $clog2(STQ_SIZE);
  localparam int ADDR_W    = 32;
  localparam int DW_BYTES  = 8;
  localparam int DW_OFS_W  = $clog2(DW_BYTES);
  localparam int DATA_W    = DW_BYTES * 8;

  typedef logic [STQ_IDX_W-1:0] stq_idx_t;
  typedef logic [STQ_IDX_W:0]   stq_cnt_t;    // 0..STQ_SIZE

  typedef enum logic [1:0] {
    ST_B = 2'd0,
    ST_H = 2'd1,
    ST_W = 2'd2,
    ST_D = 2'd3
  } st_size_e;

  // ==========================================================================
  // Payloads
  // ==========================================================================
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    st_size_e          size;
    logic [DATA_W-1:0] data;   // Low-justified
  } st_req_t;

  typedef struct packed {
    logic [ADDR_W-DW_OFS_W-1:0] dw_addr;
    logic [DW_BYTES-1:0]        byte_en;
    logic [DATA_W-1:0]          data;     // Already in lane position
  } stq_entry_t;

  typedef struct packed {
    logic              valid;
    logic [ADDR_W-1:0] addr;
    st_size_e          size;
  } fwd_query_t;

  typedef struct packed {
    logic [DW_BYTES-1:0] hit_be;
    logic [DATA_W-1:0]   data;
  } fwd_resp_t;

  typedef struct packed {
    logic [ADDR_W-1:0]   addr;   // Double-word aligned
    logic [DW_BYTES-1:0] strb;
    logic [DATA_W-1:0]   data;
  } stb_req_t;

  // Byte lanes touched by an access of the given size at offset zero
  function automatic logic [DW_BYTES-1:0] size_mask(input st_size_e size);
    logic [DW_BYTES-1:0] mask;
    case (size)
      ST_B:    mask = 8'h01;
      ST_H:    mask = 8'h03;
      ST_W:    mask = 8'h0f;
      default: mask = 8'hff;
    endcase
    return mask;
  endfunction

endpackage

`default_nettype wire

// File: design/stq_ptr_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module stq_ptr_ctrl (
  input  logic                         i_clk,
  input  logic                         i_reset_n,
  input  logic                         i_st_valid,
  input  logic                         i_commit,
  input  logic                         i_pop,
  output logic                         o_st_ready,
  output stq_pkg::stq_idx_t            o_tail_idx,
  output stq_pkg::stq_idx_t            o_head_idx,
  output logic [stq_pkg::STQ_SIZE-1:0] o_valid_mask,
  output logic                         o_head_committed
);
  import stq_pkg::*;

  // Pointers carry one wrap bit above the index
  stq_cnt_t r_head;
  stq_cnt_t r_cmt;
  stq_cnt_t r_tail;
  stq_cnt_t w_count;
  stq_cnt_t w_uncmt;
  logic     w_push;
  logic     w_cmt_en;
  logic     w_pop;

  assign w_count  = r_tail - r_head;
  assign w_uncmt  = r_tail - r_cmt;

  assign o_st_ready       = (w_count != stq_cnt_t'(STQ_SIZE));
  assign o_head_committed = (r_cmt != r_head);

  assign w_push   = i_st_valid & o_st_ready;
  assign w_cmt_en = i_commit & (w_uncmt != '0);   // Stray pulses dropped
  assign w_pop    = i_pop & o_head_committed;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_head <= '0;
      r_cmt  <= '0;
      r_tail <= '0;
    end else begin
      if (w_push) begin
        r_tail <= r_tail + stq_cnt_t'(1);
      end
      if (w_cmt_en) begin
        r_cmt <= r_cmt + stq_cnt_t'(1);
      end
      if (w_pop) begin
        r_head <= r_head + stq_cnt_t'(1);
      end
    end
  end

  assign o_tail_idx = r_tail[STQ_IDX_W-1:0];
  assign o_head_idx = r_head[STQ_IDX_W-1:0];

  // Entry is live when its distance from head is below the occupancy
  always_comb begin : valid_mask_gen
    stq_idx_t ofs;
    for (int i = 0; i < STQ_SIZE; i++) begin
      ofs             = stq_idx_t'(i) - o_head_idx;
      o_valid_mask[i] = ({1'b0, ofs} < w_count);
    end
  end

endmodule

`default_nettype wire

// File: design/stq_top.sv
`timescale 1ns/1ps
`default_nettype none

module stq_top (
  input  logic                i_clk,
  input  logic                i_reset_n,
  input  logic                i_st_valid,
  input  stq_pkg::st_req_t    i_st,
  output logic                o_st_ready,
  input  logic                i_commit,
  input  stq_pkg::fwd_query_t i_fwd,
  output stq_pkg::fwd_resp_t  o_fwd,
  output logic                o_stb_valid,
  output stq_pkg::stb_req_t   o_stb,
  input  logic                i_stb_ready
);
  import stq_pkg::*;

  stq_entry_t [STQ_SIZE-1:0] w_entries;
  stq_entry_t                w_head_entry;
  logic [STQ_SIZE-1:0]       w_valid_mask;
  stq_idx_t                  w_tail_idx;
  stq_idx_t                  w_head_idx;
  logic                      w_head_committed;
  logic                      w_pop;
  logic                      w_wr_en;

  assign w_wr_en      = i_st_valid & o_st_ready;
  assign w_head_entry = w_entries[w_head_idx];   // Oldest entry feeds the drain

  // ==========================================================================
  // Queue control and storage
  // ==========================================================================
  stq_ptr_ctrl u_ptr_ctrl (
    .i_clk            (i_clk),
    .i_reset_n        (i_reset_n),
    .i_st_valid       (i_st_valid),
    .i_commit         (i_commit),
    .i_pop            (w_pop),
    .o_st_ready       (o_st_ready),
    .o_tail_idx       (w_tail_idx),
    .o_head_idx       (w_head_idx),
    .o_valid_mask     (w_valid_mask),
    .o_head_committed (w_head_committed)
  );

  stq_entry_array u_entry_array (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_wr_en   (w_wr_en),
    .i_wr_idx  (w_tail_idx),
    .i_st      (i_st),
    .o_entries (w_entries)
  );

  // ==========================================================================
  // Load forwarding and store-buffer drain
  // ==========================================================================
  stq_fwd_unit u_fwd_unit (
    .i_entries    (w_entries),
    .i_valid_mask (w_valid_mask),
    .i_tail_idx   (w_tail_idx),
    .i_fwd        (i_fwd),
    .o_fwd        (o_fwd)
  );

  stq_drain u_drain (
    .i_clk            (i_clk),
    .i_reset_n        (i_reset_n),
    .i_head_entry     (w_head_entry),
    .i_head_committed (w_head_committed),
    .i_stb_ready      (i_stb_ready),
    .o_pop            (w_pop),
    .o_stb_valid      (o_stb_valid),
    .o_stb            (o_stb)
  );

endmodule

`default_nettype wire

// File: tb.f
design/stq_pkg.sv
design/stq_ptr_ctrl.sv
design/stq_entry_array.sv
design/stq_fwd_unit.sv
design/stq_drain.sv
design/stq_top.sv
verification/stq_tb_asserts.sv
verification/stq_tb.sv

// File: verification/stq_tb.sv
`timescale 1ns/1ps
`default_nettype none

module stq_tb;
  import stq_pkg::*;

  localparam int TEST_CYCLES = 200;               // Rough length of the whole sequence
  localparam int MAX_CYCLES  = 10 * TEST_CYCLES;
  localparam int DW_ADDR_W   = ADDR_W - DW_OFS_W;

  logic       clk;
  logic       reset_n;
  logic       st_valid;
  st_req_t    st_req;
  logic       st_ready;
  logic       commit;
  fwd_query_t fwd_q;
  fwd_resp_t  fwd_resp;
  logic       stb_valid;
  stb_req_t   stb;
  logic       stb_ready;

  int         seed      = 89;
  int         cycle_cnt = 0;
  string      test_name = "reset";

  // Reference model state
  st_req_t    model_q[$];
  int         n_cmt         = 0;   // Committed entries still queued
  logic       exp_st_ready  = 1'b1;
  logic       exp_stb_valid = 1'b0;
  stb_req_t   exp_stb       = '0;
  fwd_resp_t  exp_fwd       = '0;

  stq_top dut0 (
    .i_clk       (clk),
    .i_reset_n   (reset_n),
    .i_st_valid  (st_valid),
    .i_st        (st_req),
    .o_st_ready  (st_ready),
    .i_commit    (commit),
    .i_fwd       (fwd_q),
    .o_fwd       (fwd_resp),
    .o_stb_valid (stb_valid),
    .o_stb       (stb),
    .i_stb_ready (stb_ready)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic report_mismatch(input string sig, input logic [103:0] exp_v,
                                 input logic [103:0] act_v);
    abort_run($sformatf("MISMATCH test=%s signal=%s expected=%h actual=%h",
                        test_name, sig, exp_v, act_v));
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      abort_run($sformatf("Timeout: test %s still running after %0d cycles",
                          test_name, cycle_cnt));
    end
  end

  // ==========================================================================
  // Model functions
  // ==========================================================================
  function automatic logic [7:0] lane_mask(input st_size_e size, input logic [2:0] ofs);
    logic [15:0] m;
    m = (16'd1 << (16'd1 << size)) - 16'd1;
    m = m << ofs;
    return m[7:0];   // Lanes past the double word are lost
  endfunction

  function automatic stb_req_t to_stb(input st_req_t s);
    stb_req_t r;
    r.addr = {s.addr[ADDR_W-1:DW_OFS_W], {DW_OFS_W{1'b0}}};
    r.strb = lane_mask(s.size, s.addr[2:0]);
    r.data = s.data << (8 * s.addr[2:0]);
    return r;
  endfunction

  // Oldest first, so a younger store overwrites the byte
  function automatic fwd_resp_t fwd_ref(input fwd_query_t q);
    fwd_resp_t  r;
    logic [7:0] qbe;
    stb_req_t   e;
    r   = '0;
    qbe = lane_mask(q.size, q.addr[2:0]);
    if (q.valid) begin
      for (int i = 0; i < model_q.size(); i++) begin
        e = to_stb(model_q[i]);
        if (e.addr[ADDR_W-1:DW_OFS_W] == q.addr[ADDR_W-1:DW_OFS_W]) begin
          for (int b = 0; b < DW_BYTES; b++) begin
            if (qbe[b] && e.strb[b]) begin
              r.hit_be[b]      = 1'b1;
              r.data[b*8 +: 8] = e.data[b*8 +: 8];
            end
          end
        end
      end
    end
    return r;
  endfunction

  task automatic model_update();
    int   depth;
    int   n_unc;
    logic load;
    depth = model_q.size();
    n_unc = depth - n_cmt;
    load  = (n_cmt > 0) && (!exp_stb_valid || stb_ready);
    if (load) begin
      exp_stb       = to_stb(model_q.pop_front());
      exp_stb_valid = 1'b1;
      n_cmt--;
    end else if (stb_ready) begin
      exp_stb_valid = 1'b0;
    end
    if (commit && n_unc > 0) begin
      n_cmt++;
    end
    if (st_valid && depth < STQ_SIZE) begin
      model_q.push_back(st_req);
    end
  endtask

  // ==========================================================================
  // Checks against the model
  // ==========================================================================
  a_st_ready: assert property (@(posedge clk) disable iff (!reset_n)
      st_ready == exp_st_ready)
    else report_mismatch("o_st_ready", 104'($sampled(exp_st_ready)), 104'($sampled(st_ready)));

  a_stb_valid: assert property (@(posedge clk) disable iff (!reset_n)
      stb_valid == exp_stb_valid)
    else report_mismatch("o_stb_valid", 104'($sampled(exp_stb_valid)),
                         104'($sampled(stb_valid)));

  a_stb_req: assert property (@(posedge clk) disable iff (!reset_n)
      exp_stb_valid |-> stb == exp_stb)
    else report_mismatch("o_stb", $sampled(exp_stb), $sampled(stb));

  a_fwd: assert property (@(posedge clk) disable iff (!reset_n)
      fwd_resp == exp_fwd)
    else report_mismatch("o_fwd", 104'($sampled(exp_fwd)), 104'($sampled(fwd_resp)));

  // ==========================================================================
  // Stimulus
  // ==========================================================================
  // Expectations settle before the rising edge, model follows at the falling one
  task automatic run_cycle();
    exp_st_ready = (model_q.size() < STQ_SIZE);
    exp_fwd      = fwd_ref(fwd_q);
    @(posedge clk);
    @(negedge clk);
    model_update();
  endtask

  task automatic rand_store(input logic [DW_ADDR_W-1:0] dw, output st_req_t s);
    int          nbytes;
    logic [2:0]  ofs;
    logic [63:0] keep;
    s.size = st_size_e'(2'($random(seed)));
    nbytes = 1 << s.size;
    ofs    = 3'($random(seed)) & ~3'(nbytes - 1);   // Natural alignment
    keep   = (nbytes == 8) ? '1 : (64'd1 << (8 * nbytes)) - 64'd1;
    s.addr = {dw, ofs};
    s.data = {$random(seed), $random(seed)} & keep;
  endtask

  task automatic set_query(input logic [DW_ADDR_W-1:0] dw, input st_size_e sz,
                           input logic [2:0] ofs);
    fwd_q.valid = 1'b1;
    fwd_q.addr  = {dw, ofs};
    fwd_q.size  = sz;
  endtask

  task automatic flush_queue();
    st_valid  = 1'b0;
    stb_ready = 1'b1;
    while (model_q.size() != n_cmt) begin
      commit = 1'b1;
      run_cycle();
    end
    commit = 1'b0;
    while (model_q.size() != 0 || exp_stb_valid || stb_valid) begin
      run_cycle();
    end
  endtask

  initial begin
    logic [DW_ADDR_W-1:0] fwd_dw;
    st_valid  = 1'b0;
    st_req    = '0;
    commit    = 1'b0;
    fwd_q     = '0;
    stb_ready = 1'b1;
    reset_n   = 1'b0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;
    repeat (3) run_cycle();

    test_name = "drain";   // Random back-pressure too
    for (int i = 0; i < 24; i++) begin
      rand_store(DW_ADDR_W'($random(seed)), st_req);
      st_valid  = 1'b1;
      commit    = 1'($random(seed));
      stb_ready = 1'($random(seed));
      set_query(st_req.addr[ADDR_W-1:DW_OFS_W], st_size_e'(2'($random(seed))),
                3'($random(seed)));
      run_cycle();
    end
    fwd_q.valid = 1'b0;
    flush_queue();

    test_name = "full";
    for (int i = 0; i < 12; i++) begin
      rand_store(DW_ADDR_W'($random(seed)), st_req);
      st_valid = 1'b1;
      commit   = (i == 9);
      run_cycle();
    end
    flush_queue();

    test_name = "forward";
    stb_ready = 1'b0;
    fwd_dw    = DW_ADDR_W'($random(seed));
    for (int i = 0; i < 6; i++) begin
      rand_store((i == 3) ? fwd_dw + 1'b1 : fwd_dw, st_req);
      st_valid = 1'b1;
      commit   = (i == 1 || i == 2);   // One in the drain register, one left queued
      run_cycle();
    end
    st_valid = 1'b0;
    commit   = 1'b0;
    for (int sz = 0; sz < 4; sz++) begin
      for (int ofs = 0; ofs < DW_BYTES; ofs += (1 << sz)) begin
        set_query(fwd_dw, st_size_e'(2'(sz)), 3'(ofs));
        run_cycle();
      end
    end
    fwd_q.valid = 1'b0;
    flush_queue();

    test_name = "commit";
    commit = 1'b1;
    repeat (3) run_cycle();
    commit = 1'b0;
    rand_store(DW_ADDR_W'($random(seed)), st_req);
    st_valid = 1'b1;
    run_cycle();
    st_valid = 1'b0;
    repeat (6) run_cycle();   // Must not drain yet
    flush_queue();

    if (dut0.u_asserts.fail_cnt == 0) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      abort_run("Bound protocol assertions reported errors");
    end
  end

endmodule

`default_nettype wire

// File: verification/stq_tb_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module stq_tb_asserts (
  input logic              i_clk,
  input logic              i_reset_n,
  input logic              i_st_ready,
  input logic              i_pop,
  input logic              i_head_committed,
  input logic              i_stb_valid,
  input stq_pkg::stb_req_t i_stb,
  input logic              i_stb_ready
);

  int fail_cnt = 0;

  // Stalled request holds
  a_stb_hold: assert property (@(posedge i_clk) disable iff (!i_reset_n)
      i_stb_valid && !i_stb_ready |=> i_stb_valid && $stable(i_stb))
    else begin
      $error("store-buffer request dropped or changed while stalled");
      fail_cnt++;
    end

  a_stb_refill: assert property (@(posedge i_clk) disable iff (!i_reset_n)
      i_head_committed && (!i_stb_valid || i_stb_ready) |=> i_stb_valid)
    else begin
      $error("committed head not sent once the register was free");
      fail_cnt++;
    end

  // Full queue only opens on a pop
  a_full_hold: assert property (@(posedge i_clk) disable iff (!i_reset_n)
      !i_st_ready && !i_pop |=> !i_st_ready)
    else begin
      $error("store ready rose on a full queue without a pop");
      fail_cnt++;
    end

endmodule

bind stq_top stq_tb_asserts u_asserts (
  .i_clk            (i_clk),
  .i_reset_n        (i_reset_n),
  .i_st_ready       (o_st_ready),
  .i_pop            (w_pop),
  .i_head_committed (w_head_committed),
  .i_stb_valid      (o_stb_valid),
  .i_stb            (o_stb),
  .i_stb_ready      (i_stb_ready)
);

`default_nettype wire
